// ==== files.f ====
+incdir+source
source/booth_pkg.sv
source/booth_step_if.sv
source/booth_decode.sv
source/booth_execute.sv
source/booth_result.sv
source/booth_multiplier_32x32.sv
verification/booth_checker.sv
verification/tb_clock_gen.sv
verification/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the Booth multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f files.f \
   --top-module tb_top \
   -o tb_sim

# Keep running past assertion failures so the summary gets printed
./obj_dir/tb_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "^Simulation finished: PASS$" sim.log; then
   echo "run_sim: passed"
   exit 0
else
   echo "run_sim: failed"
   exit 1
fi

// ==== source/booth_decode.sv ====
/*
 * Decode stage of the Booth multiplier
 *   Input valid/ready handshake and operand capture
 *   Radix-4 recoding of the multiplier, one digit per cycle
 *   Step sequencing FSM with hold on a full result buffer
 */

`timescale 1ns/1ps
`default_nettype none

`include "booth_settings.svh"

module booth_decode (
   input  logic              clk,
   input  logic              rst,
   input  booth_pkg::operand_t a,
   input  booth_pkg::operand_t b,
   input  logic              in_valid_i,
   output logic              in_ready_o,
   input  logic              result_full,
   booth_step_if.decode_mp   step
);
   import booth_pkg::*;

   // Index of the final digit and the digit before it
   localparam step_count_t LAST_STEP  = step_count_t'(`BOOTH_DIGITS - 1);
   localparam step_count_t HOLD_CHECK = step_count_t'(`BOOTH_DIGITS - 2);

   decode_state_e state_q;
   step_count_t   count_q;
   // Low for one cycle after reset so the input does not open early
   logic          armed_q;
   operand_t      mcand_q;
   // Multiplier with a zero guard bit below the LSB
   logic [`BOOTH_OPERAND_W:0] mplier_q;

   logic       accept;
   logic [2:0] triple;
   digit_mag_e mag_d;
   logic       neg_d;

   assign in_ready_o = armed_q && (state_q == ST_IDLE);
   assign accept     = in_valid_i && in_ready_o;

   // --------------------------------------------------
   // Sequencing FSM
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= ST_IDLE;
         count_q <= '0;
         armed_q <= 1'b0;
      end else begin
         armed_q <= 1'b1;
         case (state_q)
            ST_IDLE: begin
               if (accept) begin
                  state_q <= ST_STEP;
                  count_q <= '0;
               end
            end
            ST_STEP: begin
               if (count_q == LAST_STEP) begin
                  // Last digit goes out now, input opens next cycle
                  state_q <= ST_IDLE;
               end else begin
                  count_q <= step_count_t'(count_q + 1'b1);
                  // Buffer still busy, keep the last digit back
                  if (count_q == HOLD_CHECK && result_full) begin
                     state_q <= ST_HOLD;
                  end
               end
            end
            ST_HOLD: begin
               if (!result_full) begin
                  state_q <= ST_STEP;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Operand registers, loaded on accept and shifted per digit
   always_ff @(posedge clk) begin
      if (accept) begin
         mcand_q  <= a;
         mplier_q <= {b, 1'b0};
      end else if (state_q == ST_STEP) begin
         mplier_q <= {{2{mplier_q[`BOOTH_OPERAND_W]}}, mplier_q[`BOOTH_OPERAND_W:2]};
      end
   end

   // --------------------------------------------------
   // Radix-4 recoding of bits {2i+1, 2i, 2i-1}
   // --------------------------------------------------
   assign triple = mplier_q[2:0];

   always_comb begin
      case (triple)
         3'b001, 3'b010, 3'b101, 3'b110: mag_d = MAG_ONE;
         3'b011, 3'b100:                 mag_d = MAG_TWO;
         default:                        mag_d = MAG_ZERO;
      endcase
      // 111 is a zero digit, keep it positive
      neg_d = triple[2] && !(triple[1] && triple[0]);
   end

   // Step bus
   assign step.step_valid   = (state_q == ST_STEP);
   assign step.first        = (count_q == '0);
   assign step.last         = (count_q == LAST_STEP);
   assign step.mag          = mag_d;
   assign step.neg          = neg_d;
   assign step.multiplicand = mcand_q;

endmodule

`default_nettype wire

// ==== source/booth_execute.sv ====
/*
 * Execute stage of the Booth multiplier
 *   Partial product from multiplicand, digit magnitude and sign
 *   Shift by twice the digit index and accumulate
 *   One-cycle product_valid pulse after the last digit
 */

`timescale 1ns/1ps
`default_nettype none

`include "booth_settings.svh"

module booth_execute (
   input  logic                clk,
   input  logic                rst,
   booth_step_if.execute_mp    step,
   output booth_pkg::product_t product,
   output logic                product_valid
);
   import booth_pkg::*;

   product_t    acc_q;
   step_count_t idx_q;
   logic        product_valid_q;

   step_count_t idx;
   product_t    mcand_ext;
   product_t    mag_val;
   product_t    signed_val;
   product_t    pp;

   // --------------------------------------------------
   // Partial product
   // --------------------------------------------------
   always_comb begin
      // Digit index restarts with every new product
      idx = step.first ? '0 : idx_q;

      mcand_ext = {{`BOOTH_OPERAND_W{step.multiplicand[`BOOTH_OPERAND_W-1]}},
                   step.multiplicand};

      case (step.mag)
         MAG_ONE: mag_val = mcand_ext;
         MAG_TWO: mag_val = mcand_ext <<< 1;
         default: mag_val = '0;
      endcase

      signed_val = step.neg ? -mag_val : mag_val;
      // Digit i weighs 4^i
      pp = signed_val <<< {idx, 1'b0};
   end

   // Digit counter and done pulse
   always_ff @(posedge clk) begin
      if (rst) begin
         idx_q           <= '0;
         product_valid_q <= 1'b0;
      end else begin
         product_valid_q <= step.step_valid && step.last;
         if (step.step_valid) begin
            idx_q <= step_count_t'(idx + 1'b1);
         end
      end
   end

   // Accumulator
   always_ff @(posedge clk) begin
      if (step.step_valid) begin
         acc_q <= step.first ? pp : acc_q + pp;
      end
   end

   assign product       = acc_q;
   assign product_valid = product_valid_q;

endmodule

`default_nettype wire

// ==== source/booth_multiplier_32x32.sv ====
/*
 * Signed 32x32 radix-4 Booth multiplier, top level
 *   Decode, execute and result stages
 *   Valid/ready handshake on input and output
 */

`timescale 1ns/1ps
`default_nettype none

module booth_multiplier_32x32 (
   input  logic                clk,
   input  logic                rst,
   input  booth_pkg::operand_t a,
   input  booth_pkg::operand_t b,
   input  logic                in_valid_i,
   output logic                in_ready_o,
   output booth_pkg::product_t resultado,
   output logic                out_valid_o,
   input  logic                out_ready_i
);
   import booth_pkg::*;

   // Execute to result
   product_t product;
   logic     product_valid;
   // Result to decode
   logic     result_full;

   // One digit per cycle from decode to execute
   booth_step_if step_bus ();

   // --------------------------------------------------
   // Stages
   // --------------------------------------------------
   booth_decode booth_decode_inst (
      .clk         (clk),
      .rst         (rst),
      .a           (a),
      .b           (b),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .result_full (result_full),
      .step        (step_bus.decode_mp)
   );

   booth_execute booth_execute_inst (
      .clk           (clk),
      .rst           (rst),
      .step          (step_bus.execute_mp),
      .product       (product),
      .product_valid (product_valid)
   );

   booth_result booth_result_inst (
      .clk           (clk),
      .rst           (rst),
      .product       (product),
      .product_valid (product_valid),
      .resultado     (resultado),
      .out_valid_o   (out_valid_o),
      .out_ready_i   (out_ready_i),
      .result_full   (result_full)
   );

endmodule

`default_nettype wire

// ==== source/booth_pkg.sv ====
/*
 * Shared types of the radix-4 Booth multiplier
 *   operand_t, product_t   data widths
 *   step_count_t           digit index
 *   digit_mag_e            recoded digit magnitude
 *   decode_state_e         decode stage FSM states
 */

`default_nettype none

`include "booth_settings.svh"

package booth_pkg;

   // --------------------------------------------------
   // Data types
   // --------------------------------------------------

   // One signed multiplicand or multiplier
   typedef logic signed [`BOOTH_OPERAND_W-1:0] operand_t;

   // Full precision signed product
   typedef logic signed [2*`BOOTH_OPERAND_W-1:0] product_t;

   // Index of the digit being processed, 0 to BOOTH_DIGITS-1
   typedef logic [$clog2(`BOOTH_DIGITS)-1:0] step_count_t;

   // --------------------------------------------------
   // Encodings
   // --------------------------------------------------

   // Magnitude of a Booth digit, sign carried separately
   typedef enum logic [1:0] {
      MAG_ZERO,
      MAG_ONE,
      MAG_TWO
   } digit_mag_e;

   // Decode FSM
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_STEP,
      ST_HOLD
   } decode_state_e;

endpackage

`default_nettype wire

// ==== source/booth_result.sv ====
/*
 * Result stage of the Booth multiplier
 *   One-entry product buffer
 *   Output valid/ready handshake
 *   Full flag back to the decode stage
 */

`timescale 1ns/1ps
`default_nettype none

module booth_result (
   input  logic                clk,
   input  logic                rst,
   input  booth_pkg::product_t product,
   input  logic                product_valid,
   output booth_pkg::product_t resultado,
   output logic                out_valid_o,
   input  logic                out_ready_i,
   output logic                result_full
);
   import booth_pkg::*;

   product_t data_q;
   logic     valid_q;
   logic     take;

   // Output transfer on this edge
   assign take = valid_q && out_ready_i;

   // --------------------------------------------------
   // Occupancy
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else if (product_valid) begin
         // New product wins over a take in the same cycle
         valid_q <= 1'b1;
      end else if (take) begin
         valid_q <= 1'b0;
      end
   end

   // Product register, held until taken
   always_ff @(posedge clk) begin
      if (product_valid) begin
         data_q <= product;
      end
   end

   assign resultado   = data_q;
   assign out_valid_o = valid_q;
   // Buffer frees up on a take, so report busy only when it stays
   assign result_full = valid_q && !out_ready_i;

endmodule

`default_nettype wire

// ==== source/booth_settings.svh ====
/*
 * Global sizing macros for the radix-4 Booth multiplier
 *   BOOTH_OPERAND_W  width of each signed operand
 *   BOOTH_DIGITS     number of radix-4 digits per multiplier
 */

`ifndef BOOTH_SETTINGS_SVH
`define BOOTH_SETTINGS_SVH

// Signed operand width in bits
`define BOOTH_OPERAND_W 32

// Radix-4 recoding retires two multiplier bits per digit
`define BOOTH_DIGITS (`BOOTH_OPERAND_W / 2)

`endif

// ==== source/booth_step_if.sv ====
/*
 * Step bus from the decode stage to the execute stage
 *   One recoded Booth digit per cycle, plus framing flags
 *   No ready signal, a valid step is consumed in the same cycle
 */

`timescale 1ns/1ps
`default_nettype none

interface booth_step_if;
   import booth_pkg::*;

   // This cycle carries a digit
   logic       step_valid;
   // Start a new accumulation
   logic       first;
   // Final digit of the current product
   logic       last;
   // Digit magnitude and sign
   digit_mag_e mag;
   logic       neg;
   // Multiplicand, constant over one product
   operand_t   multiplicand;

   // Decode side drives everything
   modport decode_mp (
      output step_valid,
      output first,
      output last,
      output mag,
      output neg,
      output multiplicand
   );

   // Execute side only samples
   modport execute_mp (
      input step_valid,
      input first,
      input last,
      input mag,
      input neg,
      input multiplicand
   );

endinterface

`default_nettype wire

// ==== verification/booth_checker.sv ====
/*
 * Concurrent assertions bound to the Booth multiplier top level
 *   Reference product queue built from accepted operands
 *   Product value, output stability, latency, handshake rules
 */

`timescale 1ns/1ps
`default_nettype none

module booth_checker (
   input logic                clk,
   input logic                rst,
   input booth_pkg::operand_t a,
   input booth_pkg::operand_t b,
   input logic                in_valid_i,
   input logic                in_ready_o,
   input booth_pkg::product_t resultado,
   input logic                out_valid_o,
   input logic                out_ready_i
);
   import booth_pkg::*;

   // Read by the testbench at the end of the run
   int       error_count = 0;

   product_t exp_q[$];
   product_t exp_head;
   int       outstanding;
   int       ready_streak;
   // Accept history, bit i set when an accept happened i+1 edges ago
   logic [16:0] acc_sr;

   logic accept;
   logic take;

   assign accept = in_valid_i && in_ready_o;
   assign take   = out_valid_o && out_ready_i;

   // --------------------------------------------------
   // Reference model state
   // --------------------------------------------------
   always @(posedge clk) begin
      if (rst) begin
         exp_q.delete();
         outstanding  <= 0;
         exp_head     <= '0;
         ready_streak <= 0;
         acc_sr       <= '0;
      end else begin
         if (take) begin
            void'(exp_q.pop_front());
         end
         // Signed product of the accepted pair
         if (accept) begin
            exp_q.push_back(product_t'(a) * product_t'(b));
         end
         outstanding  <= exp_q.size();
         exp_head     <= (exp_q.size() > 0) ? exp_q[0] : '0;
         acc_sr       <= {acc_sr[15:0], accept};
         ready_streak <= !out_ready_i ? 0 :
                         (ready_streak < 1000) ? ready_streak + 1 : ready_streak;
      end
   end

   // --------------------------------------------------
   // Properties
   // --------------------------------------------------

   // Output buffer empty right after reset
   reset_clears_valid: assert property (@(posedge clk) rst |=> !out_valid_o)
      else begin
         error_count++;
         $error("out_valid_o high in the cycle after reset");
      end

   // Taken product equals the oldest outstanding signed product
   product_matches: assert property (@(posedge clk) disable iff (rst)
      take |-> (outstanding > 0 && resultado == exp_head))
      else begin
         error_count++;
         $error("resultado 0x%016h differs from expected 0x%016h", resultado, exp_head);
      end

   // Held product does not change or vanish before the transfer
   stable_under_backpressure: assert property (@(posedge clk) disable iff (rst)
      (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(resultado)))
      else begin
         error_count++;
         $error("resultado changed or dropped while not taken");
      end

   // No valid output without an accepted operand pair
   no_spurious_output: assert property (@(posedge clk) disable iff (rst)
      out_valid_o |-> outstanding > 0)
      else begin
         error_count++;
         $error("out_valid_o high with no product outstanding");
      end

   // At most one buffered and one in computation
   inflight_limit: assert property (@(posedge clk) disable iff (rst)
      outstanding <= 2)
      else begin
         error_count++;
         $error("more than two products in flight");
      end

   // Input stays closed while one waits and the next is underway
   input_closed_when_full: assert property (@(posedge clk) disable iff (rst)
      (outstanding == 2 && out_valid_o) |-> !in_ready_o)
      else begin
         error_count++;
         $error("in_ready_o high with a buffered product and a second in flight");
      end

   // Seventeen cycles from accept to out_valid_o with ready held high
   fixed_latency: assert property (@(posedge clk) disable iff (rst)
      (acc_sr[16] && ready_streak >= 17) |-> !out_valid_o ##1 out_valid_o)
      else begin
         error_count++;
         $error("out_valid_o did not rise 17 cycles after accept");
      end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
/*
 * Clock and reset source for the testbench
 *   100 ns clock period
 *   Synchronous active-high reset held for 8 cycles
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic rst
);

   // Free running clock, 50 ns per half period
   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Reset released after the eighth rising edge
   initial begin
      rst = 1'b1;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

`default_nettype wire

// ==== verification/tb_top.sv ====
/*
 * Testbench top for the Booth multiplier
 *   DUT instance, bound checker, clock source
 *   Reset, corner, latency, back-pressure and random tests
 *   Per-test report lines and closing summary
 */

`timescale 1ns/1ps
`default_nettype none

module tb_top;
   import booth_pkg::*;

   logic     clk;
   logic     rst;
   operand_t a;
   operand_t b;
   logic     in_valid_i;
   logic     in_ready_o;
   product_t resultado;
   logic     out_valid_o;
   logic     out_ready_i;

   int       seed;
   int       tests_run;
   int       tests_failed;
   int       chk_errors;
   bit       timed_out;
   product_t exp_q[$];
   operand_t src_a[$];
   operand_t src_b[$];
   operand_t corners[7];

   tb_clock_gen clock_gen_inst (.clk(clk), .rst(rst));

   booth_multiplier_32x32 booth_multiplier_32x32_inst (
      .clk         (clk),
      .rst         (rst),
      .a           (a),
      .b           (b),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .resultado   (resultado),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

   bind booth_multiplier_32x32 booth_checker booth_checker_inst (
      .clk(clk), .rst(rst), .a(a), .b(b), .in_valid_i(in_valid_i),
      .in_ready_o(in_ready_o), .resultado(resultado), .out_valid_o(out_valid_o),
      .out_ready_i(out_ready_i)
   );

   // True with the given chance in percent
   function automatic bit roll_percent(input int pct);
      int r;
      r = $random(seed);
      return ((r & 32'h7fffffff) % 100) < pct;
   endfunction

   task automatic report_test(input string name, input int errs);
      bit failed;
      failed = (errs != 0) || timed_out;
      tests_run++;
      if (failed) begin
         tests_failed++;
      end
      $display("test %s: %s (%0d errors)", name, failed ? "failed" : "ok", errs);
   endtask

   // Marks the run as timed out
   task automatic flag_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      timed_out = 1'b1;
   endtask

   // --------------------------------------------------
   // Stream engine fed from src_a and src_b
   // --------------------------------------------------
   task automatic run_stream(input int n, input int valid_pct, input int ready_pct,
                             input int hold, output int errs);
      int sent;
      int got;
      int cyc;
      int stall;
      bit drop_valid;
      product_t exp;
      sent = 0;
      got = 0;
      cyc = 0;
      stall = 0;
      errs = 0;
      drop_valid = 1'b0;
      while (got < n && !timed_out) begin
         @(negedge clk);
         cyc++;
         stall++;
         if (stall > 300) begin
            flag_timeout("a handshake in the operand stream");
            errs++;
            break;
         end
         if (drop_valid) begin
            in_valid_i = 1'b0;
            drop_valid = 1'b0;
         end
         // Offer the next pair and keep it until accepted
         if (!in_valid_i && sent < n && roll_percent(valid_pct)) begin
            a = src_a.pop_front();
            b = src_b.pop_front();
            in_valid_i = 1'b1;
         end
         out_ready_i = (cyc <= hold) ? 1'b0 : roll_percent(ready_pct);
         // Handshakes that complete on the coming rising edge
         if (in_valid_i && in_ready_o) begin
            exp_q.push_back(product_t'(a) * product_t'(b));
            sent++;
            drop_valid = 1'b1;
            stall = 0;
         end
         if (out_valid_o && out_ready_i) begin
            exp = exp_q.pop_front();
            if (resultado !== exp) begin
               errs++;
               $display("[ERROR] resultado got 0x%016h expected 0x%016h", resultado, exp);
            end
            got++;
            stall = 0;
         end
      end
      @(negedge clk);
      in_valid_i = 1'b0;
      out_ready_i = 1'b0;
   endtask

   initial begin
      int errs;
      int cnt;
      a = '0;
      b = '0;
      in_valid_i = 1'b0;
      out_ready_i = 1'b0;
      seed = 35024;
      tests_run = 0;
      tests_failed = 0;
      timed_out = 1'b0;

      // out_valid_o stays low in reset and one cycle after
      errs = 0;
      cnt = 0;
      @(negedge clk);
      while (rst) begin
         if (out_valid_o !== 1'b0) begin
            errs++;
            $display("[ERROR] out_valid_o got 0x%0h expected 0x0", out_valid_o);
         end
         cnt++;
         if (cnt > 20) begin
            flag_timeout("reset release");
            errs++;
            break;
         end
         @(negedge clk);
      end
      if (out_valid_o !== 1'b0) begin
         errs++;
         $display("[ERROR] out_valid_o got 0x%0h expected 0x0", out_valid_o);
      end
      report_test("reset", errs);

      // Every pairing of the corner values
      corners = '{32'h0, 32'h1, 32'hffffffff, 32'h7fffffff, 32'h80000000,
                  32'haaaaaaaa, 32'h55555555};
      for (int i = 0; i < 7; i++) begin
         for (int j = 0; j < 7; j++) begin
            src_a.push_back(corners[i]);
            src_b.push_back(corners[j]);
         end
      end
      run_stream(49, 100, 100, 0, errs);
      report_test("corner operands", errs);

      // Back-to-back issue with the output always ready
      for (int i = 0; i < 4; i++) begin
         src_a.push_back($random(seed));
         src_b.push_back($random(seed));
      end
      run_stream(4, 100, 100, 0, errs);
      report_test("latency", errs);

      // Output stalled long enough for the decode stage to hold
      for (int i = 0; i < 3; i++) begin
         src_a.push_back($random(seed));
         src_b.push_back($random(seed));
      end
      run_stream(3, 100, 100, 60, errs);
      report_test("back-pressure", errs);

      // Random operands with random handshakes
      for (int i = 0; i < 200; i++) begin
         src_a.push_back($random(seed));
         src_b.push_back($random(seed));
      end
      run_stream(200, 70, 60, 0, errs);
      report_test("random stream", errs);

      repeat (2) @(negedge clk);
      chk_errors = booth_multiplier_32x32_inst.booth_checker_inst.error_count;
      $display("tests run %0d, failed %0d, assertion failures %0d",
               tests_run, tests_failed, chk_errors);
      if (!timed_out && tests_failed == 0 && chk_errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
